/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - files:
      - src/mips_pkg.sv
      - src/instruction_fetch.sv
      - src/instruction_decode.sv
      - src/execute.sv
      - src/memory_access.sv
      - src/top_mips.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_top_mips.sv

/* src/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  wire logic                             i_clk,
    input  wire logic                             i_rst_n,
    input  wire logic [mips_pkg::LEN-1:0]         i_pc_plus4,
    input  wire logic [mips_pkg::LEN-1:0]         i_read_data1,
    input  wire logic [mips_pkg::LEN-1:0]         i_read_data2,
    input  wire logic [mips_pkg::LEN-1:0]         i_imm,
    input  wire logic [mips_pkg::NB_REG_ADDR-1:0] i_rt,
    input  wire logic [mips_pkg::NB_REG_ADDR-1:0] i_rd,
    input  wire logic                             i_reg_write,
    input  wire logic                             i_mem_to_reg,
    input  wire logic                             i_mem_read,
    input  wire logic                             i_mem_write,
    input  wire logic                             i_branch,
    input  wire logic                             i_reg_dst,
    input  wire logic                             i_alu_src,
    input  wire logic [mips_pkg::NB_ALU_OP-1:0]   i_alu_op,
    output logic                                  o_pc_src,
    output logic      [mips_pkg::LEN-1:0]         o_branch_target,
    output logic      [mips_pkg::LEN-1:0]         o_alu_result,
    output logic      [mips_pkg::LEN-1:0]         o_store_data,
    output logic      [mips_pkg::NB_REG_ADDR-1:0] o_dest_reg,
    output logic                                  o_reg_write,
    output logic                                  o_mem_to_reg,
    output logic                                  o_mem_write
);

    logic [mips_pkg::NB_ALU_CTRL-1:0] alu_ctrl;
    logic [mips_pkg::LEN-1:0]         op_b, alu_out;

    // ALU control from alu_op and funct (low bits of the immediate)
    always_comb begin
        case (i_alu_op)
            mips_pkg::ALU_OP_SUB:   alu_ctrl = mips_pkg::ALU_SUB;
            mips_pkg::ALU_OP_FUNCT: begin
                case (i_imm[mips_pkg::NB_FUNCT-1:0])
                    mips_pkg::FN_SUB: alu_ctrl = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: alu_ctrl = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  alu_ctrl = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT: alu_ctrl = mips_pkg::ALU_SLT;
                    default:          alu_ctrl = mips_pkg::ALU_ADD;  // FN_ADD and nop
                endcase
            end
            default:                alu_ctrl = mips_pkg::ALU_ADD;
        endcase
    end

    assign op_b = i_alu_src ? i_imm : i_read_data2;

    always_comb begin
        case (alu_ctrl)
            mips_pkg::ALU_AND: alu_out = i_read_data1 & op_b;
            mips_pkg::ALU_OR:  alu_out = i_read_data1 | op_b;
            mips_pkg::ALU_SUB: alu_out = i_read_data1 - op_b;
            mips_pkg::ALU_SLT: alu_out = {{(mips_pkg::LEN-1){1'b0}},
                                          $signed(i_read_data1) < $signed(op_b)};
            default:           alu_out = i_read_data1 + op_b;
        endcase
    end

    // Branch resolution, redirects fetch at the end of this cycle
    assign o_branch_target = i_pc_plus4 + {i_imm[mips_pkg::LEN-3:0], 2'b00};
    assign o_pc_src        = i_branch && (i_read_data1 == i_read_data2);

    ////////////////////////////////////////////////////////////
    // EX/MEM latch
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || o_pc_src) begin
            {o_reg_write, o_mem_to_reg, o_mem_write} <= '0;
        end else begin
            o_reg_write  <= i_reg_write;
            o_mem_to_reg <= i_mem_to_reg && i_mem_read;  // Load data only on a real read
            o_mem_write  <= i_mem_write;
        end
    end

    always_ff @(posedge i_clk) begin
        o_alu_result <= alu_out;
        o_store_data <= i_read_data2;
        o_dest_reg   <= i_reg_dst ? i_rd : i_rt;
    end

endmodule

`default_nettype wire

/* src/instruction_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_decode (
    input  wire logic                                i_clk,
    input  wire logic                                i_rst_n,
    input  wire logic                                i_flush,
    input  wire logic [mips_pkg::LEN-1:0]            i_instr,
    input  wire logic [mips_pkg::LEN-1:0]            i_pc_plus4,
    input  wire logic                                i_wb_en,
    input  wire logic [mips_pkg::NB_REG_ADDR-1:0]    i_wb_reg,
    input  wire logic [mips_pkg::LEN-1:0]            i_wb_data,
    input  wire logic [mips_pkg::NB_REG_ADDR-1:0]    i_dbg_addr,
    output logic      [mips_pkg::LEN-1:0]            o_dbg_data,
    output logic      [mips_pkg::LEN-1:0]            o_pc_plus4,
    output logic      [mips_pkg::LEN-1:0]            o_read_data1,
    output logic      [mips_pkg::LEN-1:0]            o_read_data2,
    output logic      [mips_pkg::LEN-1:0]            o_imm,
    output logic      [mips_pkg::NB_REG_ADDR-1:0]    o_rt,
    output logic      [mips_pkg::NB_REG_ADDR-1:0]    o_rd,
    output logic                                     o_reg_write,
    output logic                                     o_mem_to_reg,
    output logic                                     o_mem_read,
    output logic                                     o_mem_write,
    output logic                                     o_branch,
    output logic                                     o_reg_dst,
    output logic                                     o_alu_src,
    output logic      [mips_pkg::NB_ALU_OP-1:0]      o_alu_op
);

    logic [mips_pkg::LEN-1:0] regs [mips_pkg::N_REGS];

    logic [mips_pkg::NB_OPCODE-1:0]   opcode;
    logic [mips_pkg::NB_REG_ADDR-1:0] rs, rt, rd;
    logic [mips_pkg::LEN-1:0]         rd1, rd2, imm_ext;
    logic reg_write, mem_to_reg, mem_read, mem_write, branch, reg_dst, alu_src;
    logic [mips_pkg::NB_ALU_OP-1:0]   alu_op;

    assign opcode  = i_instr[31:26];
    assign rs      = i_instr[25:21];
    assign rt      = i_instr[20:16];
    assign rd      = i_instr[15:11];
    assign imm_ext = {{(mips_pkg::LEN-mips_pkg::NB_IMM){i_instr[15]}},
                      i_instr[mips_pkg::NB_IMM-1:0]};

    ////////////////////////////////////////////////////////////
    // Register file, written by WB with no bypass
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < mips_pkg::N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_en && (i_wb_reg != '0)) begin
            regs[i_wb_reg] <= i_wb_data;
        end
    end

    assign rd1        = (rs == '0) ? '0 : regs[rs];
    assign rd2        = (rt == '0) ? '0 : regs[rt];
    assign o_dbg_data = (i_dbg_addr == '0) ? '0 : regs[i_dbg_addr];

    // Main control
    always_comb begin
        {reg_write, mem_to_reg, mem_read, mem_write} = '0;
        {branch, reg_dst, alu_src}                   = '0;
        alu_op                                       = mips_pkg::ALU_OP_ADD;
        case (opcode)
            mips_pkg::OP_RTYPE: begin   // Nop lands here with rd 0
                reg_write = 1'b1;
                reg_dst   = 1'b1;
                alu_op    = mips_pkg::ALU_OP_FUNCT;
            end
            mips_pkg::OP_ADDI: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            mips_pkg::OP_LW: begin
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
                mem_read   = 1'b1;
                alu_src    = 1'b1;
            end
            mips_pkg::OP_SW: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                branch = 1'b1;
                alu_op = mips_pkg::ALU_OP_SUB;
            end
            default: ;                  // Unknown opcode acts as nop
        endcase
    end

    ////////////////////////////////////////////////////////////
    // ID/EX latch
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_flush) begin
            {o_reg_write, o_mem_to_reg, o_mem_read, o_mem_write} <= '0;
            {o_branch, o_reg_dst, o_alu_src}                     <= '0;
            o_alu_op                                             <= mips_pkg::ALU_OP_ADD;
        end else begin
            {o_reg_write, o_mem_to_reg, o_mem_read, o_mem_write} <=
                {reg_write, mem_to_reg, mem_read, mem_write};
            {o_branch, o_reg_dst, o_alu_src} <= {branch, reg_dst, alu_src};
            o_alu_op                         <= alu_op;
        end
    end

    always_ff @(posedge i_clk) begin
        o_pc_plus4   <= i_pc_plus4;
        o_read_data1 <= rd1;
        o_read_data2 <= rd2;
        o_imm        <= imm_ext;
        o_rt         <= rt;
        o_rd         <= rd;
    end

endmodule

`default_nettype wire

/* src/instruction_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch (
    input  wire logic                              i_clk,
    input  wire logic                              i_rst_n,
    input  wire logic                              i_pc_src,
    input  wire logic [mips_pkg::LEN-1:0]          i_branch_target,
    input  wire logic                              i_imem_we,
    input  wire logic [mips_pkg::NB_IMEM_ADDR-1:0] i_imem_addr,
    input  wire logic [mips_pkg::LEN-1:0]          i_imem_data,
    output logic      [mips_pkg::LEN-1:0]          o_instr,
    output logic      [mips_pkg::LEN-1:0]          o_pc_plus4
);

    logic [mips_pkg::LEN-1:0] imem [mips_pkg::IMEM_DEPTH];
    logic [mips_pkg::LEN-1:0] pc;
    logic [mips_pkg::LEN-1:0] pc_next4;
    logic [mips_pkg::NB_IMEM_ADDR-1:0] pc_word;

    assign pc_next4 = pc + 32'd4;
    assign pc_word  = pc[mips_pkg::NB_IMEM_ADDR+1:2];   // Byte PC to word index

    // Program load only while the core is held in reset
    always_ff @(posedge i_clk) begin
        if (!i_rst_n && i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // PC and IF/ID latch
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc         <= '0;
            o_instr    <= '0;       // Nop
            o_pc_plus4 <= '0;
        end else if (i_pc_src) begin
            pc         <= i_branch_target;
            o_instr    <= '0;       // Squash the wrong-path word
            o_pc_plus4 <= '0;
        end else begin
            pc         <= pc_next4;
            o_instr    <= imem[pc_word];
            o_pc_plus4 <= pc_next4;
        end
    end

endmodule

`default_nettype wire

/* src/memory_access.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_access (
    input  wire logic                             i_clk,
    input  wire logic                             i_rst_n,
    input  wire logic [mips_pkg::LEN-1:0]         i_alu_result,
    input  wire logic [mips_pkg::LEN-1:0]         i_store_data,
    input  wire logic [mips_pkg::NB_REG_ADDR-1:0] i_dest_reg,
    input  wire logic                             i_reg_write,
    input  wire logic                             i_mem_to_reg,
    input  wire logic                             i_mem_write,
    output logic                                  o_wb_en,
    output logic      [mips_pkg::NB_REG_ADDR-1:0] o_wb_reg,
    output logic      [mips_pkg::LEN-1:0]         o_wb_data
);

    logic [mips_pkg::LEN-1:0]          dmem [mips_pkg::DMEM_DEPTH];
    logic [mips_pkg::NB_DMEM_ADDR-1:0] word_addr;
    logic [mips_pkg::LEN-1:0]          load_data;

    assign word_addr = i_alu_result[mips_pkg::NB_DMEM_ADDR+1:2];
    assign load_data = dmem[word_addr];     // Asynchronous read

    // Data memory starts out all zero
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < mips_pkg::DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_mem_write) begin
            dmem[word_addr] <= i_store_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // MEM/WB latch, also the commit stream
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_wb_en <= 1'b0;
        end else begin
            o_wb_en <= i_reg_write && (i_dest_reg != '0);  // r0 writes never commit
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_reg  <= i_dest_reg;
        o_wb_data <= i_mem_to_reg ? load_data : i_alu_result;
    end

endmodule

`default_nettype wire

/* src/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and depths
    ////////////////////////////////////////////////////////////
    localparam int LEN          = 32;
    localparam int NB_REG_ADDR  = 5;
    localparam int N_REGS       = 32;
    localparam int NB_OPCODE    = 6;
    localparam int NB_FUNCT     = 6;
    localparam int NB_IMM       = 16;   // Immediate field before extension

    localparam int IMEM_DEPTH   = 256;  // Words
    localparam int DMEM_DEPTH   = 64;   // Words
    localparam int NB_IMEM_ADDR = 8;
    localparam int NB_DMEM_ADDR = 6;

    ////////////////////////////////////////////////////////////
    // Opcodes and function codes
    ////////////////////////////////////////////////////////////
    localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'h00;
    localparam logic [NB_OPCODE-1:0] OP_ADDI  = 6'h08;
    localparam logic [NB_OPCODE-1:0] OP_LW    = 6'h23;
    localparam logic [NB_OPCODE-1:0] OP_SW    = 6'h2b;
    localparam logic [NB_OPCODE-1:0] OP_BEQ   = 6'h04;

    localparam logic [NB_FUNCT-1:0] FN_ADD = 6'h20;
    localparam logic [NB_FUNCT-1:0] FN_SUB = 6'h22;
    localparam logic [NB_FUNCT-1:0] FN_AND = 6'h24;
    localparam logic [NB_FUNCT-1:0] FN_OR  = 6'h25;
    localparam logic [NB_FUNCT-1:0] FN_SLT = 6'h2a;

    ////////////////////////////////////////////////////////////
    // ALU selectors
    ////////////////////////////////////////////////////////////
    localparam int NB_ALU_OP = 2;   // Decode to execute
    localparam logic [NB_ALU_OP-1:0] ALU_OP_ADD   = 2'b00;  // Address calc and addi
    localparam logic [NB_ALU_OP-1:0] ALU_OP_SUB   = 2'b01;  // Branch compare
    localparam logic [NB_ALU_OP-1:0] ALU_OP_FUNCT = 2'b10;  // Look at funct field

    localparam int NB_ALU_CTRL = 4;
    localparam logic [NB_ALU_CTRL-1:0] ALU_AND = 4'b0000;
    localparam logic [NB_ALU_CTRL-1:0] ALU_OR  = 4'b0001;
    localparam logic [NB_ALU_CTRL-1:0] ALU_ADD = 4'b0010;
    localparam logic [NB_ALU_CTRL-1:0] ALU_SUB = 4'b0110;
    localparam logic [NB_ALU_CTRL-1:0] ALU_SLT = 4'b0111;

endpackage

`default_nettype wire

/* src/top_mips.sv */
`timescale 1ns/1ps
`default_nettype none

module top_mips (
    input  wire logic                              i_clk,
    input  wire logic                              i_rst_n,
    input  wire logic                              i_imem_we,
    input  wire logic [mips_pkg::NB_IMEM_ADDR-1:0] i_imem_addr,
    input  wire logic [mips_pkg::LEN-1:0]          i_imem_data,
    input  wire logic [mips_pkg::NB_REG_ADDR-1:0]  i_dbg_addr,
    output logic                                   o_commit_valid,
    output logic      [mips_pkg::NB_REG_ADDR-1:0]  o_commit_reg,
    output logic      [mips_pkg::LEN-1:0]          o_commit_data,
    output logic      [mips_pkg::LEN-1:0]          o_dbg_data
);

    // Fetch side
    logic                     pc_src;
    logic [mips_pkg::LEN-1:0] branch_target, if_instr, if_pc_plus4;

    // ID/EX
    logic [mips_pkg::LEN-1:0]         id_pc_plus4, id_rd1, id_rd2, id_imm;
    logic [mips_pkg::NB_REG_ADDR-1:0] id_rt, id_rd;
    logic id_reg_write, id_mem_to_reg, id_mem_read, id_mem_write;
    logic id_branch, id_reg_dst, id_alu_src;
    logic [mips_pkg::NB_ALU_OP-1:0]   id_alu_op;

    // EX/MEM
    logic [mips_pkg::LEN-1:0]         ex_alu_result, ex_store_data;
    logic [mips_pkg::NB_REG_ADDR-1:0] ex_dest_reg;
    logic ex_reg_write, ex_mem_to_reg, ex_mem_write;

    ////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////
    instruction_fetch u_instruction_fetch (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_pc_src(pc_src), .i_branch_target(branch_target),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .o_instr(if_instr), .o_pc_plus4(if_pc_plus4)
    );

    instruction_decode u_instruction_decode (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_flush(pc_src),
        .i_instr(if_instr), .i_pc_plus4(if_pc_plus4),
        .i_wb_en(o_commit_valid), .i_wb_reg(o_commit_reg), .i_wb_data(o_commit_data),
        .i_dbg_addr(i_dbg_addr), .o_dbg_data(o_dbg_data),
        .o_pc_plus4(id_pc_plus4), .o_read_data1(id_rd1), .o_read_data2(id_rd2),
        .o_imm(id_imm), .o_rt(id_rt), .o_rd(id_rd),
        .o_reg_write(id_reg_write), .o_mem_to_reg(id_mem_to_reg),
        .o_mem_read(id_mem_read), .o_mem_write(id_mem_write), .o_branch(id_branch),
        .o_reg_dst(id_reg_dst), .o_alu_src(id_alu_src), .o_alu_op(id_alu_op)
    );

    execute u_execute (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_pc_plus4(id_pc_plus4), .i_read_data1(id_rd1), .i_read_data2(id_rd2),
        .i_imm(id_imm), .i_rt(id_rt), .i_rd(id_rd),
        .i_reg_write(id_reg_write), .i_mem_to_reg(id_mem_to_reg),
        .i_mem_read(id_mem_read), .i_mem_write(id_mem_write), .i_branch(id_branch),
        .i_reg_dst(id_reg_dst), .i_alu_src(id_alu_src), .i_alu_op(id_alu_op),
        .o_pc_src(pc_src), .o_branch_target(branch_target),
        .o_alu_result(ex_alu_result), .o_store_data(ex_store_data),
        .o_dest_reg(ex_dest_reg), .o_reg_write(ex_reg_write),
        .o_mem_to_reg(ex_mem_to_reg), .o_mem_write(ex_mem_write)
    );

    memory_access u_memory_access (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_alu_result(ex_alu_result), .i_store_data(ex_store_data),
        .i_dest_reg(ex_dest_reg), .i_reg_write(ex_reg_write),
        .i_mem_to_reg(ex_mem_to_reg), .i_mem_write(ex_mem_write),
        .o_wb_en(o_commit_valid), .o_wb_reg(o_commit_reg), .o_wb_data(o_commit_data)
    );

endmodule

`default_nettype wire

/* tb.f */
src/mips_pkg.sv
src/instruction_fetch.sv
src/instruction_decode.sv
src/execute.sv
src/memory_access.sv
src/top_mips.sv
tests/tb_clock_gen.sv
tests/tb_top_mips.sv

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    input  wire logic i_hold,       // High while the program is loaded
    output logic      o_clk,
    output logic      o_rst_n
);

    localparam int HALF_PERIOD  = 5;    // 10 ns clock
    localparam int RESET_CYCLES = 3;

    int low_cycles;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // Reset low during the load, then for three more cycles
    initial begin
        o_rst_n    = 1'b0;
        low_cycles = 0;
        while (low_cycles < RESET_CYCLES) begin
            @(posedge o_clk);
            if (i_hold) begin
                low_cycles = 0;
            end else begin
                low_cycles++;
            end
        end
        @(negedge o_clk);
        o_rst_n = 1'b1;             // Released on a falling edge
    end

endmodule

`default_nettype wire

/* tests/tb_top_mips.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top_mips;

    localparam int N_INSTR         = 40;
    localparam int GROUP           = 4;                         // Instruction and three nops
    localparam int LOOP_WORD       = N_INSTR * GROUP;           // Final beq to itself
    localparam int N_WORDS         = LOOP_WORD + GROUP;
    localparam int WATCHDOG_CYCLES = 20 * N_WORDS + 100;
    localparam int DRAIN_CYCLES    = 10;

    logic                              clk;
    logic                              rst_n;
    logic                              load_busy;
    logic                              imem_we;
    logic [mips_pkg::NB_IMEM_ADDR-1:0] imem_addr;
    logic [mips_pkg::LEN-1:0]          imem_data;
    logic [mips_pkg::NB_REG_ADDR-1:0]  dbg_addr;
    logic                              commit_valid;
    logic [mips_pkg::NB_REG_ADDR-1:0]  commit_reg;
    logic [mips_pkg::LEN-1:0]          commit_data;
    logic [mips_pkg::LEN-1:0]          dbg_data;

    logic [31:0] lfsr_state;
    logic [31:0] prog [N_WORDS];
    logic [31:0] model_regs [mips_pkg::N_REGS];
    logic [31:0] model_mem [mips_pkg::DMEM_DEPTH];
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_data [$];
    int          commit_count = 0;

    tb_clock_gen clk_gen_i (.i_hold(load_busy), .o_clk(clk), .o_rst_n(rst_n));

    top_mips dut_i (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_imem_we(imem_we), .i_imem_addr(imem_addr), .i_imem_data(imem_data),
        .i_dbg_addr(dbg_addr),
        .o_commit_valid(commit_valid), .o_commit_reg(commit_reg),
        .o_commit_data(commit_data), .o_dbg_data(dbg_data)
    );

    ////////////////////////////////////////////////////////////
    // Error handling and checks
    ////////////////////////////////////////////////////////////
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_itype(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Half the accesses fall in the low four words so loads hit stores
    function automatic logic [15:0] mem_offset();
        logic [5:0] w;
        w = random_bits(1) ? random_bits(6) : random_bits(2);
        return {8'd0, w, 2'b00};
    endfunction

    ////////////////////////////////////////////////////////////
    // Program generator
    ////////////////////////////////////////////////////////////
    task automatic build_program();
        logic [2:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [5:0]  fn;
        logic [15:0] imm;
        logic [31:0] word;
        int          skip;
        for (int i = 0; i < N_INSTR; i++) begin
            kind = random_bits(3);
            rs   = random_bits(3);          // Registers 0 to 7
            rt   = random_bits(3);
            rd   = random_bits(3);
            imm  = random_bits(16);
            case (kind)
                3'd0, 3'd1, 3'd2: begin
                    case (random_bits(3) % 5)
                        0:       fn = mips_pkg::FN_ADD;
                        1:       fn = mips_pkg::FN_SUB;
                        2:       fn = mips_pkg::FN_AND;
                        3:       fn = mips_pkg::FN_OR;
                        default: fn = mips_pkg::FN_SLT;
                    endcase
                    word = {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
                end
                3'd3, 3'd4: word = enc_itype(mips_pkg::OP_ADDI, rs, rt, imm);
                3'd5:       word = enc_itype(mips_pkg::OP_LW, 5'd0, rt, mem_offset());
                3'd6:       word = enc_itype(mips_pkg::OP_SW, 5'd0, rt, mem_offset());
                default: begin
                    skip = random_bits(2) % 3;
                    if (skip > N_INSTR - 1 - i) begin
                        skip = N_INSTR - 1 - i;     // Never jump past the final loop
                    end
                    word = enc_itype(mips_pkg::OP_BEQ, rs, rt, 16'(skip * GROUP));
                end
            endcase
            prog[i*GROUP] = word;
            for (int k = 1; k < GROUP; k++) begin
                prog[i*GROUP+k] = 32'd0;
            end
        end
        prog[LOOP_WORD] = enc_itype(mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'hffff);
        for (int k = 1; k < GROUP; k++) begin
            prog[LOOP_WORD+k] = 32'd0;
        end
    endtask

    // Sequential instruction-set model
    task automatic run_model();
        int          pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0]  dest;
        logic        writes;
        for (int r = 0; r < mips_pkg::N_REGS; r++) begin
            model_regs[r] = '0;
        end
        for (int m = 0; m < mips_pkg::DMEM_DEPTH; m++) begin
            model_mem[m] = '0;
        end
        pc = 0;
        while (pc != LOOP_WORD) begin
            w      = prog[pc];
            a      = model_regs[w[25:21]];
            b      = model_regs[w[20:16]];
            simm   = {{16{w[15]}}, w[15:0]};
            addr   = a + simm;
            writes = 1'b0;
            dest   = '0;
            res    = '0;
            pc     = pc + 1;
            case (w[31:26])
                mips_pkg::OP_RTYPE: begin
                    writes = 1'b1;
                    dest   = w[15:11];
                    case (w[5:0])
                        mips_pkg::FN_SUB: res = a - b;
                        mips_pkg::FN_AND: res = a & b;
                        mips_pkg::FN_OR:  res = a | b;
                        mips_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:          res = a + b;
                    endcase
                end
                mips_pkg::OP_ADDI: begin
                    writes = 1'b1;
                    dest   = w[20:16];
                    res    = a + simm;
                end
                mips_pkg::OP_LW: begin
                    writes = 1'b1;
                    dest   = w[20:16];
                    res    = model_mem[addr[7:2]];
                end
                mips_pkg::OP_SW:  model_mem[addr[7:2]] = b;
                mips_pkg::OP_BEQ: if (a == b) pc = pc + int'($signed(simm));
                default: ;
            endcase
            if (writes && dest != 5'd0) begin   // r0 never commits
                model_regs[dest] = res;
                exp_reg.push_back(dest);
                exp_data.push_back(res);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Commit monitor sampled mid-cycle
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (commit_valid === 1'b1) begin
            if (commit_count >= exp_reg.size()) begin
                fail_run("The DUT committed a result that the model does not expect");
            end else begin
                check_value("o_commit_reg", 32'(commit_reg), 32'(exp_reg[commit_count]));
                check_value("o_commit_data", commit_data, exp_data[commit_count]);
                commit_count++;
            end
        end else if (commit_valid !== 1'b0) begin
            fail_run("o_commit_valid is unknown");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("Watchdog expired before all expected commits arrived");
    end

    initial begin
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_data  = '0;
        dbg_addr   = '0;
        load_busy  = 1'b1;
        lfsr_state = 32'h12d1;
        build_program();
        run_model();

        for (int w = 0; w < N_WORDS; w++) begin
            @(negedge clk);
            imem_we   = 1'b1;
            imem_addr = w[mips_pkg::NB_IMEM_ADDR-1:0];
            imem_data = prog[w];
        end
        @(negedge clk);
        imem_we   = 1'b0;
        load_busy = 1'b0;                       // Reset ends three cycles later

        wait (rst_n === 1'b1);
        wait (commit_count == exp_reg.size());
        repeat (DRAIN_CYCLES) @(negedge clk);   // Catch stray commits

        // Final register state through the debug port
        for (int r = 0; r < mips_pkg::N_REGS; r++) begin
            @(negedge clk);
            dbg_addr = r[mips_pkg::NB_REG_ADDR-1:0];
            @(posedge clk);
            check_value($sformatf("o_dbg_data[r%0d]", r), dbg_data, model_regs[r]);
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
